// ==== source/fetch_macros.svh ====
//////////////////////////////////////////////////
// Default sizes and constants of the fetch stage.
// Reset vector, BTB and BHT depths, cache lines
// and the sequential instruction step.
//////////////////////////////////////////////////

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// First PC after reset.
`define FETCH_RESET_VECTOR 32'h0000_0000

// Predictor and cache depths, all powers of two.
`define FETCH_BTB_ENTRIES  16
`define FETCH_BHT_ENTRIES  64
`define FETCH_ICACHE_LINES 32

// Sequential step, no compressed instructions.
`define FETCH_INSTR_BYTES  4

`endif

// ==== source/fetch_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the fetch stage.
// Address and word, IF/ID payload, prediction
// and the refill states.
//////////////////////////////////////////////////

package fetch_pkg;

    // Byte address and instruction word.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Payload handed to Decode.
    typedef struct packed {
        addr_t pc;
        word_t instr;
        logic  fault;
    } if_id_t;

    // Prediction made for the fetched instruction.
    typedef struct packed {
        logic  taken;
        addr_t target;
        logic  hit;
    } bp_pred_t;

    // Refill FSM states.
    typedef enum logic [1:0] {LOOKUP, REQ, WAIT} fetch_state_e;

endpackage

// ==== source/pc_gen.sv ====
//////////////////////////////////////////////////
// Program counter register.
// Next PC by priority: redirect, prediction, +4.
//////////////////////////////////////////////////

`include "fetch_macros.svh"

module pc_gen
    import fetch_pkg::*;
#(
    parameter addr_t RESET_VECTOR = `FETCH_RESET_VECTOR
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  advance_i,
    input  logic  redirect_i,
    input  addr_t redirect_target_i,
    input  logic  pred_taken_i,
    input  addr_t pred_target_i,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t pc_d;

    // Redirect wins, then a predicted taken branch.
    // The prediction already carries the BTB hit.
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_target_i;
        end else if (pred_taken_i) begin
            pc_d = pred_target_i;
        end else begin
            pc_d = pc_q + addr_t'(`FETCH_INSTR_BYTES);
        end
    end

    // A redirect loads even while the stage waits or stalls.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= RESET_VECTOR;
        end else if (redirect_i || advance_i) begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // Targets from redirects and the BTB must keep the PC on word boundaries.
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pc_o[1:0] == 2'b00);

endmodule

// ==== source/fetch_ctrl.sv ====
//////////////////////////////////////////////////
// Refill FSM of the instruction cache.
// Turns a miss into a memory request, a fill and
// a delivery towards Decode.
//////////////////////////////////////////////////

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  addr_t pc_i,
    input  logic  hit_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    output logic  req_valid_o,
    input  logic  req_ready_i,
    output addr_t req_addr_o,
    input  logic  rsp_valid_i,
    input  logic  rsp_error_i,
    output logic  rsp_ready_o,
    output logic  fetch_valid_o,
    output logic  advance_o,
    output logic  fault_o,
    output logic  fill_o,
    output addr_t fill_addr_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        miss_addr_q;
    logic         drop_q;
    logic         rsp_take;
    logic         deliver;

    // Response accepted; always ready while waiting.
    assign rsp_take = (state_q == WAIT) && rsp_valid_i;

    // Old-path data still fills but never reaches Decode.
    assign deliver  = rsp_take && !drop_q && !redirect_i;

    //////////////////////////////////////////////////
    // State transitions
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            LOOKUP: begin
                // No refill for a PC that is being replaced.
                if (!hit_i && !redirect_i) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (req_ready_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (rsp_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= LOOKUP;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Remember a redirect seen while the refill is open.
            if (state_q == LOOKUP) begin
                drop_q <= 1'b0;
            end else if (redirect_i) begin
                drop_q <= 1'b1;
            end
        end
    end

    // Miss address, held through REQ and WAIT.
    always_ff @(posedge clk_i) begin
        if (state_q == LOOKUP) begin
            miss_addr_q <= pc_i;
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    assign req_valid_o   = (state_q == REQ);
    assign req_addr_o    = miss_addr_q;
    assign rsp_ready_o   = (state_q == WAIT);

    // Error responses are never cached.
    assign fill_o        = rsp_take && !rsp_error_i;
    assign fill_addr_o   = miss_addr_q;

    assign fetch_valid_o = ((state_q == LOOKUP) && hit_i && !redirect_i) || deliver;
    assign fault_o       = deliver && rsp_error_i;
    assign advance_o     = fetch_valid_o && !stall_i;

    // A pending request keeps its address until the memory takes it.
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_addr_o));

    // A response outside the WAIT window would be lost.
    a_rsp_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i |-> rsp_ready_o);

endmodule

// ==== source/icache.sv ====
//////////////////////////////////////////////////
// Direct-mapped instruction cache, one-word lines.
// Combinational lookup, single-line fill with
// bypass, and invalidate of all lines.
//////////////////////////////////////////////////

`include "fetch_macros.svh"

module icache
    import fetch_pkg::*;
#(
    parameter int unsigned LINES = `FETCH_ICACHE_LINES
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  addr_t pc_i,
    output logic  hit_o,
    output word_t instr_o,
    input  logic  fill_i,
    input  addr_t fill_addr_i,
    input  word_t fill_data_i,
    input  logic  invalidate_i
);

    localparam int unsigned IDX_W = $clog2(LINES);
    localparam int unsigned TAG_W = 32 - IDX_W - 2;

    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [LINES];
    word_t            data_q [LINES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [TAG_W-1:0] wr_tag;
    logic             bypass;

    // Word address bits select the line, the rest is tag.
    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[31:IDX_W+2];
    assign wr_idx = fill_addr_i[IDX_W+1:2];
    assign wr_tag = fill_addr_i[31:IDX_W+2];

    // Fill word goes straight out in the fill cycle.
    assign bypass  = fill_i && (fill_addr_i == pc_i);
    assign hit_o   = bypass || (valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag));
    assign instr_o = bypass ? fill_data_i : data_q[rd_idx];

    // Invalidate takes priority over a fill in the same cycle.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (invalidate_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= fill_data_i;
        end
    end

endmodule

// ==== source/branch_predictor.sv ====
//////////////////////////////////////////////////
// Branch predictor for the fetch stage.
// Direct-mapped BTB plus a table of 2-bit
// saturating counters, updated from Execute.
//////////////////////////////////////////////////

`include "fetch_macros.svh"

module branch_predictor
    import fetch_pkg::*;
#(
    parameter int unsigned BTB_ENTRIES = `FETCH_BTB_ENTRIES,
    parameter int unsigned BHT_ENTRIES = `FETCH_BHT_ENTRIES
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  addr_t pc_i,
    output logic  pred_taken_o,
    output addr_t pred_target_o,
    output logic  hit_o,
    input  logic  upd_valid_i,
    input  addr_t upd_pc_i,
    input  logic  upd_taken_i,
    input  addr_t upd_target_i,
    input  logic  upd_is_branch_i
);

    localparam int unsigned BTB_IDX_W = $clog2(BTB_ENTRIES);
    localparam int unsigned BTB_TAG_W = 32 - BTB_IDX_W - 2;
    localparam int unsigned BHT_IDX_W = $clog2(BHT_ENTRIES);

    logic [BTB_ENTRIES-1:0] btb_valid_q;
    logic [BTB_TAG_W-1:0]   btb_tag_q [BTB_ENTRIES];
    addr_t                  btb_target_q [BTB_ENTRIES];
    logic [1:0]             bht_q [BHT_ENTRIES];

    logic [BTB_IDX_W-1:0] rd_btb_idx;
    logic [BTB_IDX_W-1:0] upd_btb_idx;
    logic [BTB_TAG_W-1:0] rd_tag;
    logic [BTB_TAG_W-1:0] upd_tag;
    logic [BHT_IDX_W-1:0] rd_bht_idx;
    logic [BHT_IDX_W-1:0] upd_bht_idx;

    assign rd_btb_idx  = pc_i[BTB_IDX_W+1:2];
    assign rd_tag      = pc_i[31:BTB_IDX_W+2];
    assign rd_bht_idx  = pc_i[BHT_IDX_W+1:2];
    assign upd_btb_idx = upd_pc_i[BTB_IDX_W+1:2];
    assign upd_tag     = upd_pc_i[31:BTB_IDX_W+2];
    assign upd_bht_idx = upd_pc_i[BHT_IDX_W+1:2];

    //////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////

    assign hit_o         = btb_valid_q[rd_btb_idx] && (btb_tag_q[rd_btb_idx] == rd_tag);
    // Counter high bit, only trusted with a known target.
    assign pred_taken_o  = hit_o && bht_q[rd_bht_idx][1];
    assign pred_target_o = btb_target_q[rd_btb_idx];

    //////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////

    // Counters start weakly not taken.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht_q[i] <= 2'b01;
            end
        end else if (upd_valid_i && upd_is_branch_i) begin
            if (upd_taken_i && (bht_q[upd_bht_idx] != 2'b11)) begin
                bht_q[upd_bht_idx] <= bht_q[upd_bht_idx] + 2'b01;
            end else if (!upd_taken_i && (bht_q[upd_bht_idx] != 2'b00)) begin
                bht_q[upd_bht_idx] <= bht_q[upd_bht_idx] - 2'b01;
            end
        end
    end

    // Taken updates allocate or refresh a BTB entry.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            btb_valid_q <= '0;
        end else if (upd_valid_i && upd_taken_i) begin
            btb_valid_q[upd_btb_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_valid_i && upd_taken_i) begin
            btb_tag_q[upd_btb_idx]    <= upd_tag;
            btb_target_q[upd_btb_idx] <= upd_target_i;
        end
    end

endmodule

// ==== source/pipe_reg.sv ====
//////////////////////////////////////////////////
// Stage register with stall and flush, generic
// over its payload type.
//////////////////////////////////////////////////

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  T     d_i,
    input  logic valid_i,
    input  logic stall_i,
    input  logic flush_i,
    output T     q_o,
    output logic valid_o
);

    T     q_q;
    logic valid_q;

    // Stall holds, flush empties the stage.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= flush_i ? 1'b0 : valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            q_q <= flush_i ? T'('0) : d_i;
        end
    end

    assign q_o     = q_q;
    assign valid_o = valid_q;

endmodule

// ==== source/fetch_stage.sv ====
//////////////////////////////////////////////////
// Instruction fetch stage, top level.
// PC, predictor, cache, refill FSM and the IF/ID
// registers towards Decode.
//////////////////////////////////////////////////

`include "fetch_macros.svh"

module fetch_stage
    import fetch_pkg::*;
#(
    parameter addr_t       RESET_VECTOR = `FETCH_RESET_VECTOR,
    parameter int unsigned BTB_ENTRIES  = `FETCH_BTB_ENTRIES,
    parameter int unsigned BHT_ENTRIES  = `FETCH_BHT_ENTRIES,
    parameter int unsigned ICACHE_LINES = `FETCH_ICACHE_LINES
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    // Hazard controls and redirect.
    input  logic  stall_i,
    input  logic  flush_i,
    input  logic  redirect_i,
    input  addr_t redirect_target_i,
    // Predictor update from Execute.
    input  logic  bp_upd_valid_i,
    input  addr_t bp_upd_pc_i,
    input  logic  bp_upd_taken_i,
    input  addr_t bp_upd_target_i,
    input  logic  bp_upd_is_branch_i,
    // Memory request and response.
    output logic  req_valid_o,
    input  logic  req_ready_i,
    output addr_t req_addr_o,
    input  logic  rsp_valid_i,
    input  word_t rsp_data_i,
    input  logic  rsp_error_i,
    output logic  rsp_ready_o,
    // Towards Decode.
    output logic  if_id_valid_o,
    output addr_t if_id_pc_o,
    output word_t if_id_instr_o,
    output logic  if_id_fault_o,
    output logic  pred_taken_o,
    output addr_t pred_target_o,
    output addr_t pc_o
);

    addr_t    pc;
    logic     ic_hit;
    word_t    ic_instr;
    logic     bp_taken;
    addr_t    bp_target;
    logic     bp_hit;
    logic     fetch_valid;
    logic     advance;
    logic     fault;
    logic     fill;
    addr_t    fill_addr;
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    bp_pred_t pred_d;
    bp_pred_t pred_q;
    logic     pred_valid;

    pc_gen #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_pc_gen (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .advance_i        (advance),
        .redirect_i       (redirect_i),
        .redirect_target_i(redirect_target_i),
        .pred_taken_i     (bp_taken),
        .pred_target_i    (bp_target),
        .pc_o             (pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pc_i         (pc),
        .hit_i        (ic_hit),
        .stall_i      (stall_i),
        .redirect_i   (redirect_i),
        .req_valid_o  (req_valid_o),
        .req_ready_i  (req_ready_i),
        .req_addr_o   (req_addr_o),
        .rsp_valid_i  (rsp_valid_i),
        .rsp_error_i  (rsp_error_i),
        .rsp_ready_o  (rsp_ready_o),
        .fetch_valid_o(fetch_valid),
        .advance_o    (advance),
        .fault_o      (fault),
        .fill_o       (fill),
        .fill_addr_o  (fill_addr)
    );

    // Flush also drops every cached line.
    icache #(
        .LINES(ICACHE_LINES)
    ) u_icache (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .pc_i        (pc),
        .hit_o       (ic_hit),
        .instr_o     (ic_instr),
        .fill_i      (fill),
        .fill_addr_i (fill_addr),
        .fill_data_i (rsp_data_i),
        .invalidate_i(flush_i)
    );

    branch_predictor #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .BHT_ENTRIES(BHT_ENTRIES)
    ) u_branch_predictor (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .pc_i           (pc),
        .pred_taken_o   (bp_taken),
        .pred_target_o  (bp_target),
        .hit_o          (bp_hit),
        .upd_valid_i    (bp_upd_valid_i),
        .upd_pc_i       (bp_upd_pc_i),
        .upd_taken_i    (bp_upd_taken_i),
        .upd_target_i   (bp_upd_target_i),
        .upd_is_branch_i(bp_upd_is_branch_i)
    );

    ///////////////////////////////////////////////////
    // IF/ID registers
    ///////////////////////////////////////////////////

    // Faulted entries carry no instruction bits.
    assign if_id_d.pc     = pc;
    assign if_id_d.instr  = fault ? word_t'(0) : ic_instr;
    assign if_id_d.fault  = fault;

    assign pred_d.taken   = bp_taken;
    assign pred_d.target  = bp_target;
    assign pred_d.hit     = bp_hit;

    pipe_reg #(
        .T(if_id_t)
    ) u_if_id_reg (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (if_id_d),
        .valid_i(fetch_valid),
        .stall_i(stall_i),
        .flush_i(flush_i),
        .q_o    (if_id_q),
        .valid_o(if_id_valid_o)
    );

    pipe_reg #(
        .T(bp_pred_t)
    ) u_pred_reg (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (pred_d),
        .valid_i(fetch_valid),
        .stall_i(stall_i),
        .flush_i(flush_i),
        .q_o    (pred_q),
        .valid_o(pred_valid)
    );

    assign if_id_pc_o    = if_id_q.pc;
    assign if_id_instr_o = if_id_q.instr;
    assign if_id_fault_o = if_id_q.fault;
    // Prediction only counts alongside a valid entry.
    assign pred_taken_o  = pred_valid && pred_q.taken;
    assign pred_target_o = pred_q.target;
    assign pc_o          = pc;

endmodule

// ==== tests/tb_fetch_stage.sv ====
//////////////////////////////////////////////////
// Testbench of the fetch stage.
// Memory model with random delays, IF/ID monitor
// and a runner for the pattern file commands.
//////////////////////////////////////////////////

module tb_fetch_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PAT_WORDS     = 384;
    localparam int WAIT_CYCLES   = 300;
    localparam logic [31:0] FILL = 32'h1357_9bdf;

    typedef struct {
        int          stamp;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] target;
        logic        fault;
        logic        taken;
    } entry_t;

    logic        clk_i;
    logic        rst_ni;
    logic        stall_i;
    logic        flush_i;
    logic        redirect_i;
    logic [31:0] redirect_target_i;
    logic        bp_upd_valid_i;
    logic [31:0] bp_upd_pc_i;
    logic        bp_upd_taken_i;
    logic [31:0] bp_upd_target_i;
    logic        bp_upd_is_branch_i;
    logic        req_valid_o;
    logic        req_ready_i;
    logic [31:0] req_addr_o;
    logic        rsp_valid_i;
    logic [31:0] rsp_data_i;
    logic        rsp_error_i;
    logic        rsp_ready_o;
    logic        if_id_valid_o;
    logic [31:0] if_id_pc_o;
    logic [31:0] if_id_instr_o;
    logic        if_id_fault_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic [31:0] pc_o;

    logic [31:0] pat [0:PAT_WORDS-1];
    logic [31:0] mem [logic [31:0]];
    logic        err_addr [logic [31:0]];
    entry_t      mon_q [$];
    logic [31:0] lfsr = 32'h96e6;
    int          cyc = 0;
    logic        loaded = 1'b0;
    int          mark = 0;
    int          last_stamp = 0;
    int          errors = 0;
    int          tests = 0;
    logic        timed_out = 1'b0;
    logic [31:0] watch_addr = 32'hffff_ffff;
    int          watch_count = 0;

    fetch_stage fetch_stage_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Random delays
    //////////////////////////////////////////////////

    // Galois LFSR, one step per bit.
    function automatic logic lfsr_step();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'ha300_0000;
        return b;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    int          mstate = 0;
    int          mdelay = 0;
    logic [31:0] maddr;

    // Word held at an address, a fill pattern where the image has none.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : addr ^ FILL;
    endfunction

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            mstate = 0;
            req_ready_i = 1'b0;
            rsp_valid_i = 1'b0;
        end else begin
            case (mstate)
                0: begin
                    if (req_valid_o) begin
                        mdelay = rand_bits(2);
                        mstate = 1;
                    end
                end
                1: begin
                    if (mdelay == 0) begin
                        req_ready_i = 1'b1;
                        maddr = req_addr_o;
                        mstate = 2;
                    end else begin
                        mdelay--;
                    end
                end
                2: begin
                    // Handshake happened at the last rising edge.
                    req_ready_i = 1'b0;
                    mdelay = rand_bits(2);
                    if (maddr == watch_addr) watch_count++;
                    mstate = 3;
                end
                3: begin
                    if (mdelay == 0) begin
                        assert (rsp_ready_o) else begin
                            $display("ERR %0t: rsp_ready_o low while a response is due", $time);
                            errors++;
                        end
                        rsp_valid_i = 1'b1;
                        rsp_error_i = err_addr.exists(maddr);
                        rsp_data_i = rsp_error_i ? 32'h0 : mem_word(maddr);
                        mstate = 4;
                    end else begin
                        mdelay--;
                    end
                end
                default: begin
                    rsp_valid_i = 1'b0;
                    rsp_error_i = 1'b0;
                    mstate = 0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // IF/ID monitor
    //////////////////////////////////////////////////

    // A new entry is loaded at every rising edge without stall.
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        loaded <= rst_ni && !stall_i;
    end

    always @(negedge clk_i) begin
        entry_t e;
        if (loaded && if_id_valid_o) begin
            e.stamp  = cyc;
            e.pc     = if_id_pc_o;
            e.instr  = if_id_instr_o;
            e.target = pred_target_o;
            e.fault  = if_id_fault_o;
            e.taken  = pred_taken_o;
            mon_q.push_back(e);
        end
    end

    //////////////////////////////////////////////////
    // Runner tasks
    //////////////////////////////////////////////////

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    // Next entry newer than the last redirect mark.
    task automatic next_entry(output entry_t e);
        int waited;
        waited = 0;
        forever begin
            while (mon_q.size() > 0 && mon_q[0].stamp <= mark) begin
                void'(mon_q.pop_front());
            end
            if (mon_q.size() > 0 || waited >= WAIT_CYCLES) break;
            @(negedge clk_i);
            waited++;
        end
        if (mon_q.size() == 0) begin
            report_timeout("an IF/ID entry");
        end else begin
            e = mon_q.pop_front();
        end
    endtask

    task automatic check_entry(input logic [31:0] pc, input logic [31:0] instr,
                               input logic fault, input int mode,
                               input logic [31:0] target);
        entry_t e;
        next_entry(e);
        if (!timed_out) begin
            assert (e.pc == pc && e.instr == instr && e.fault == fault) else begin
                $display("ERR %0t: entry pc %h instr %h fault %b, expected %h %h %b",
                         $time, e.pc, e.instr, e.fault, pc, instr, fault);
                errors++;
            end
            // Mode 1 needs back-to-back delivery, mode 2 a taken prediction.
            if (mode == 1) begin
                assert (e.stamp == last_stamp + 1) else begin
                    $display("ERR %0t: entry %h not in the cycle after the previous",
                             $time, pc);
                    errors++;
                end
            end
            if (mode == 2) begin
                assert (e.taken && e.target == target) else begin
                    $display("ERR %0t: pc %h prediction %b %h, expected taken to %h",
                             $time, e.pc, e.taken, e.target, target);
                    errors++;
                end
            end else begin
                assert (!e.taken) else begin
                    $display("ERR %0t: unexpected taken prediction at %h", $time, e.pc);
                    errors++;
                end
            end
            last_stamp = e.stamp;
        end
    endtask

    task automatic do_redirect(input logic [31:0] target, input logic mid_refill);
        int waited;
        waited = 0;
        while (mid_refill && !req_valid_o && waited < WAIT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (waited >= WAIT_CYCLES) begin
            report_timeout("a memory request");
        end else begin
            redirect_i = 1'b1;
            redirect_target_i = target;
            mark = cyc;
            @(negedge clk_i);
            redirect_i = 1'b0;
        end
    endtask

    task automatic bp_update(input logic [31:0] pc, input logic [31:0] target,
                             input logic taken);
        bp_upd_valid_i = 1'b1;
        bp_upd_is_branch_i = 1'b1;
        bp_upd_pc_i = pc;
        bp_upd_target_i = target;
        bp_upd_taken_i = taken;
        @(negedge clk_i);
        bp_upd_valid_i = 1'b0;
    endtask

    task automatic hold_stall(input int cycles);
        logic [31:0] pc_s;
        logic [31:0] ipc_s;
        logic [31:0] instr_s;
        logic        valid_s;
        // Values before the first stalled edge.
        pc_s = pc_o;
        ipc_s = if_id_pc_o;
        instr_s = if_id_instr_o;
        valid_s = if_id_valid_o;
        stall_i = 1'b1;
        repeat (cycles) begin
            @(negedge clk_i);
            assert (pc_o == pc_s && if_id_pc_o == ipc_s && if_id_instr_o == instr_s &&
                    if_id_valid_o == valid_s) else begin
                $display("ERR %0t: outputs moved during stall", $time);
                errors++;
            end
        end
        stall_i = 1'b0;
    endtask

    task automatic pulse_flush();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        assert (!if_id_valid_o) else begin
            $display("ERR %0t: if_id_valid_o still high after flush", $time);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        int          test_errors;
        stall_i = 1'b0;
        flush_i = 1'b0;
        redirect_i = 1'b0;
        redirect_target_i = '0;
        bp_upd_valid_i = 1'b0;
        bp_upd_pc_i = '0;
        bp_upd_taken_i = 1'b0;
        bp_upd_target_i = '0;
        bp_upd_is_branch_i = 1'b0;
        req_ready_i = 1'b0;
        rsp_valid_i = 1'b0;
        rsp_data_i = '0;
        rsp_error_i = 1'b0;
        rst_ni = 1'b0;
        for (int i = 0; i < PAT_WORDS; i++) pat[i] = '0;
        $readmemh("tests/fetch_patterns.txt", pat);

        // Memory image and error addresses go in before reset ends.
        for (int i = 0; i + 2 < PAT_WORDS; i += 3) begin
            if (pat[i] == 32'h1) mem[pat[i+1]] = pat[i+2];
            if (pat[i] == 32'h2) err_addr[pat[i+1]] = 1'b1;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_errors = 0;
        for (int i = 0; i + 2 < PAT_WORDS && pat[i] != 32'h0 && !timed_out; i += 3) begin
            op = pat[i];
            a = pat[i+1];
            b = pat[i+2];
            case (op)
                32'h1, 32'h2: ;
                32'h3: do_redirect(a, b[0]);
                32'h4: check_entry(a, b, 1'b0, 0, 32'h0);
                32'h5: check_entry(a, 32'h0, 1'b1, 0, 32'h0);
                32'h6: bp_update(a, b, 1'b1);
                32'h7: bp_update(a, b, 1'b0);
                32'h8: hold_stall(a);
                32'h9: pulse_flush();
                32'ha: begin
                    watch_addr = a;
                    watch_count = 0;
                end
                32'hb: begin
                    assert (watch_count == b) else begin
                        $display("ERR %0t: %0d requests for %h, expected %0d",
                                 $time, watch_count, watch_addr, b);
                        errors++;
                    end
                end
                32'hd: check_entry(a, b, 1'b0, 1, 32'h0);
                // Predicted entry carries the branch from the memory image.
                32'he: check_entry(a, mem_word(a), 1'b0, 2, b);
                32'hf: begin
                    tests++;
                    $display("Test %0d finished with %0d errors", a, errors - test_errors);
                    test_errors = errors;
                end
                default: begin
                    $display("Unknown command %h in the pattern file", op);
                    errors++;
                end
            endcase
        end

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/fetch_patterns.txt ====
// Columns: command, address, data (hex). 1 memory word, 2 error address, 3 redirect
// (data 1 waits for a refill), 4 entry, 5 fault entry, 6/7 taken/not-taken update,
// 8 stall cycles, 9 flush, A watch address, B request count, D back-to-back entry,
// E predicted entry with target, F end of test, 0 end.
1 00000000 00000013
1 00000004 00100093
1 00000008 00200113
1 0000000c 00308193
1 00000040 00a00513
1 00000044 00b00593
1 00000100 01000613
1 00000300 fe000ee3
1 00000304 00400693
1 00000340 03400713
2 00000200 00000000
// Sequential misses, then the same loop from the cache.
4 00000000 00000013
4 00000004 00100093
4 00000008 00200113
4 0000000c 00308193
3 00000000 00000000
4 00000000 00000013
d 00000004 00100093
d 00000008 00200113
d 0000000c 00308193
f 00000001 00000000
// Redirect alone and during a refill.
3 00000040 00000000
4 00000040 00a00513
4 00000044 00b00593
3 00000100 00000001
4 00000100 01000613
f 00000002 00000000
// Error response, not cached.
a 00000200 00000000
3 00000200 00000000
5 00000200 00000000
3 00000200 00000000
5 00000200 00000000
b 00000000 00000002
f 00000003 00000000
// Stall, then flush empties the cache.
3 00000040 00000000
4 00000040 00a00513
8 00000005 00000000
9 00000000 00000000
a 00000040 00000000
3 00000040 00000000
4 00000040 00a00513
b 00000000 00000001
f 00000004 00000000
// Counter 1 to 3, then back down to 1.
6 00000300 00000340
6 00000300 00000340
3 00000300 00000000
e 00000300 00000340
4 00000340 03400713
7 00000300 00000340
3 00000300 00000000
e 00000300 00000340
4 00000340 03400713
7 00000300 00000340
3 00000300 00000000
4 00000300 fe000ee3
4 00000304 00400693
f 00000005 00000000
0 00000000 00000000

// ==== verilog.f ====
+incdir+source
source/fetch_pkg.sv
source/pc_gen.sv
source/fetch_ctrl.sv
source/icache.sv
source/branch_predictor.sv
source/pipe_reg.sv
source/fetch_stage.sv
tests/tb_fetch_stage.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/pc_gen.sv
      - source/fetch_ctrl.sv
      - source/icache.sv
      - source/branch_predictor.sv
      - source/pipe_reg.sv
      - source/fetch_stage.sv
  - target: test
    files:
      - tests/tb_fetch_stage.sv
